//--- sim.f
rtl/wbPkg.sv
rtl/execResultIf.sv
rtl/completionIf.sv
rtl/intExecUnit.sv
rtl/intRegWriteStage.sv
rtl/intRegFile.sv
rtl/completionTable.sv
rtl/intWritebackTop.sv
verif/intWritebackTb.sv

//--- run.sh
#!/bin/sh
# Build and run the writeback testbench with Verilator

rm -f sim.log
verilator --binary --timing -f sim.f --top-module intWritebackTb -o intWritebackSim \
    && { ./obj_dir/intWritebackSim > sim.log 2>&1 || true; }
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verif/intWritebackTb.sv
////////////////////////////////////////
// Testbench for the integer writeback top level
// Random issue traffic against a two-slot shadow pipeline
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module intWritebackTb;
    import wbPkg::*;

    localparam int SEED = 85836;
    localparam int OP_CYCLES = 600;
    localparam int DRAIN_CYCLES = 3;
    // Covers reset, issue cycles and drain plus margin
    localparam int TIMEOUT_CYCLES = 700;

    typedef struct packed {
        logic valid;
        logic dataValid;
        logic writeReg;
        logic isBr;
        logic taken;
        logic missPred;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic [4:0] dst;
        logic [3:0] ptr;
    } OpSlot;

    logic ctrl;
    logic rst;
    logic issueValid;
    IntOpType issueOp;
    logic [31:0] issueSrcA;
    logic [31:0] issueSrcB;
    logic [31:0] issueImm;
    logic [31:0] issuePc;
    logic [31:0] issuePredNextPc;
    logic [4:0] issueDst;
    logic issueWriteReg;
    logic [3:0] issueAlPtr;
    logic issueOperandReady;
    logic stall;
    logic clear;
    logic flushValid;
    logic [3:0] flushHead;
    logic [3:0] flushTail;
    logic brValid;
    logic [31:0] brNextPc;
    logic replayValid;
    logic [3:0] replayAlPtr;
    logic [4:0] regReadNum;
    logic [31:0] regReadData;
    logic [3:0] alReadPtr;
    ExecState alReadState;
    logic [31:0] alReadFaultAddr;

    int seed = SEED;
    int cycleCount = 0;
    logic [3:0] alCount = '0;

    // Shadow pipeline and shadow storage
    OpSlot exSlot;
    OpSlot wbSlot;
    logic [31:0] shadowReg [32];
    ExecState shadowState [16];
    logic [31:0] shadowFault [16];

    intWritebackTop u_intWritebackTop (
        .ctrl(ctrl),
        .rst(rst),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueSrcA(issueSrcA),
        .issueSrcB(issueSrcB),
        .issueImm(issueImm),
        .issuePc(issuePc),
        .issuePredNextPc(issuePredNextPc),
        .issueDst(issueDst),
        .issueWriteReg(issueWriteReg),
        .issueAlPtr(issueAlPtr),
        .issueOperandReady(issueOperandReady),
        .stall(stall),
        .clear(clear),
        .flushValid(flushValid),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .brValid(brValid),
        .brNextPc(brNextPc),
        .replayValid(replayValid),
        .replayAlPtr(replayAlPtr),
        .regReadNum(regReadNum),
        .regReadData(regReadData),
        .alReadPtr(alReadPtr),
        .alReadState(alReadState),
        .alReadFaultAddr(alReadFaultAddr)
    );

    initial begin
        ctrl = 1'b0;
        forever #20 ctrl = ~ctrl;
    end

    always @(posedge ctrl) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run hung: cycle limit of %0d reached before the end", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", testName, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic bit oneIn(input int n);
        int r;
        r = $random(seed);
        return ((r & 32'h7fffffff) % n) == 0;
    endfunction

    // Circular range from head up to but not including tail
    function automatic bit inFlushRange(input logic [3:0] ptr);
        if (flushHead == flushTail) begin
            return 1'b0;
        end
        if (flushHead < flushTail) begin
            return (ptr >= flushHead) && (ptr < flushTail);
        end
        return (ptr >= flushHead) || (ptr < flushTail);
    endfunction

    function automatic OpSlot modelExecute();
        OpSlot s;
        logic [31:0] pcNext4;
        s = '0;
        pcNext4 = issuePc + 32'd4;
        s.valid = issueValid;
        s.dataValid = issueOperandReady;
        s.writeReg = issueWriteReg;
        s.dst = issueDst;
        s.ptr = issueAlPtr;
        case (issueOp)
            INT_OP_ADD: s.result = issueSrcA + issueSrcB;
            INT_OP_SUB: s.result = issueSrcA - issueSrcB;
            INT_OP_AND: s.result = issueSrcA & issueSrcB;
            INT_OP_OR:  s.result = issueSrcA | issueSrcB;
            INT_OP_XOR: s.result = issueSrcA ^ issueSrcB;
            INT_OP_BEQ: begin
                s.isBr = 1'b1;
                s.taken = (issueSrcA == issueSrcB);
            end
            INT_OP_BNE: begin
                s.isBr = 1'b1;
                s.taken = (issueSrcA != issueSrcB);
            end
            INT_OP_JAL: begin
                s.isBr = 1'b1;
                s.taken = 1'b1;
                s.result = pcNext4;
            end
        endcase
        s.nextPc = s.taken ? (issuePc + issueImm) : pcNext4;
        s.missPred = s.isBr && (s.nextPc != issuePredNextPc);
        return s;
    endfunction

    task automatic driveInputs(input bit idle);
        if (idle) begin
            issueValid = 1'b0;
            stall = 1'b0;
            clear = 1'b0;
            flushValid = 1'b0;
        end else begin
            issueValid = !oneIn(5);
            issueOp = IntOpType'(3'($random(seed)));
            issueSrcA = $random(seed);
            issueSrcB = oneIn(3) ? issueSrcA : $random(seed);
            issuePc = $random(seed) & 32'hffff_fffc;
            issueImm = $random(seed) & 32'hffff_fffc;
            // Roughly one branch in eight gets a misaligned target
            if (oneIn(8)) begin
                issueImm = issueImm | 32'(2'($random(seed)));
            end
            issuePredNextPc = oneIn(2) ? (issuePc + issueImm) : (issuePc + 32'd4);
            issueDst = 5'($random(seed));
            issueWriteReg = !oneIn(8);
            issueAlPtr = alCount;
            alCount = alCount + 4'd1;
            issueOperandReady = !oneIn(8);
            stall = oneIn(6);
            clear = oneIn(40);
            flushValid = oneIn(10);
            flushHead = 4'($random(seed));
            flushTail = 4'($random(seed));
        end
        regReadNum = 5'($random(seed));
        alReadPtr = 4'($random(seed));
    endtask

    // Check this cycle's strobes and then apply the coming clock edge to the model
    task automatic stepModel();
        bit update;
        update = wbSlot.valid && !stall && !clear && !(flushValid && inFlushRange(wbSlot.ptr));
        checkValue("brValid", 32'(update && wbSlot.dataValid && wbSlot.isBr), 32'(brValid));
        if (brValid) begin
            checkValue("brNextPc", wbSlot.nextPc, brNextPc);
        end
        checkValue("replayValid", 32'(update && !wbSlot.dataValid), 32'(replayValid));
        if (replayValid) begin
            checkValue("replayAlPtr", 32'(wbSlot.ptr), 32'(replayAlPtr));
        end
        checkValue("regRead", shadowReg[regReadNum], regReadData);
        checkValue("alState", 32'(shadowState[alReadPtr]), 32'(alReadState));
        checkValue("alFault", shadowFault[alReadPtr], alReadFaultAddr);
        if (update) begin
            if (wbSlot.writeReg && wbSlot.dataValid) begin
                shadowReg[wbSlot.dst] = wbSlot.result;
            end
            shadowFault[wbSlot.ptr] = '0;
            if (!wbSlot.dataValid) begin
                shadowState[wbSlot.ptr] = EXEC_STATE_NOT_FINISHED;
            end else if (wbSlot.isBr && wbSlot.taken && wbSlot.nextPc[1:0] != 2'b00) begin
                shadowState[wbSlot.ptr] = EXEC_STATE_FAULT_INSN_MISALIGNED;
                shadowFault[wbSlot.ptr] = wbSlot.nextPc;
            end else if (wbSlot.missPred) begin
                shadowState[wbSlot.ptr] = EXEC_STATE_REFETCH_NEXT;
            end else begin
                shadowState[wbSlot.ptr] = EXEC_STATE_SUCCESS;
            end
        end
        if (!stall) begin
            wbSlot = exSlot;
            exSlot = modelExecute();
        end
        if (clear) begin
            wbSlot.valid = 1'b0;
            exSlot.valid = 1'b0;
        end
    endtask

    task automatic runCycle(input bit idle);
        @(negedge ctrl);
        driveInputs(idle);
        #1;
        stepModel();
    endtask

    // Walk both read ports inside one low clock phase
    task automatic sweepReadPorts(input string testName);
        for (int i = 0; i < 32; i++) begin
            regReadNum = i[4:0];
            alReadPtr = i[3:0];
            #0.5;
            checkValue({testName, " reg"}, shadowReg[i[4:0]], regReadData);
            checkValue({testName, " state"}, 32'(shadowState[i[3:0]]), 32'(alReadState));
            checkValue({testName, " fault"}, shadowFault[i[3:0]], alReadFaultAddr);
        end
    endtask

    initial begin
        rst = 1'b1;
        issueOp = INT_OP_ADD;
        issueSrcA = '0;
        issueSrcB = '0;
        issueImm = '0;
        issuePc = '0;
        issuePredNextPc = '0;
        issueDst = '0;
        issueWriteReg = 1'b0;
        issueAlPtr = '0;
        issueOperandReady = 1'b0;
        flushHead = '0;
        flushTail = '0;
        driveInputs(1'b1);
        exSlot = '0;
        wbSlot = '0;
        for (int i = 0; i < 32; i++) begin
            shadowReg[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            shadowState[i] = EXEC_STATE_NOT_FINISHED;
            shadowFault[i] = '0;
        end
        repeat (4) @(posedge ctrl);
        @(negedge ctrl);
        rst = 1'b0;
        #1;
        checkValue("reset brValid", 32'd0, 32'(brValid));
        checkValue("reset replayValid", 32'd0, 32'(replayValid));
        sweepReadPorts("reset");
        for (int n = 0; n < OP_CYCLES; n++) begin
            runCycle(1'b0);
        end
        for (int n = 0; n < DRAIN_CYCLES; n++) begin
            runCycle(1'b1);
        end
        @(negedge ctrl);
        sweepReadPorts("final");
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/intWritebackTop.sv
////////////////////////////////////////
// Integer writeback subsystem top level
// Execution unit, register-write stage, register file
// and completion table behind plain ports
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module intWritebackTop #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int phyRegCount = wbPkg::PHY_REG_COUNT,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
) (
    input wire ctrl,
    input wire rst,
    // Issue
    input wire issueValid,
    input var wbPkg::IntOpType issueOp,
    input wire [dataWidth-1:0] issueSrcA,
    input wire [dataWidth-1:0] issueSrcB,
    input wire [dataWidth-1:0] issueImm,
    input wire [dataWidth-1:0] issuePc,
    input wire [dataWidth-1:0] issuePredNextPc,
    input wire [$clog2(phyRegCount)-1:0] issueDst,
    input wire issueWriteReg,
    input wire [$clog2(activeListDepth)-1:0] issueAlPtr,
    input wire issueOperandReady,
    // Backend control and selective flush
    input wire stall,
    input wire clear,
    input wire flushValid,
    input wire [$clog2(activeListDepth)-1:0] flushHead,
    input wire [$clog2(activeListDepth)-1:0] flushTail,
    // Fetch and replay
    output logic brValid,
    output logic [dataWidth-1:0] brNextPc,
    output logic replayValid,
    output logic [$clog2(activeListDepth)-1:0] replayAlPtr,
    // Observation
    input wire [$clog2(phyRegCount)-1:0] regReadNum,
    output logic [dataWidth-1:0] regReadData,
    input wire [$clog2(activeListDepth)-1:0] alReadPtr,
    output wbPkg::ExecState alReadState,
    output logic [dataWidth-1:0] alReadFaultAddr
);
    logic regWe;
    logic [$clog2(phyRegCount)-1:0] regNum;
    logic [dataWidth-1:0] regData;

    execResultIf #(
        .dataWidth(dataWidth),
        .phyRegCount(phyRegCount),
        .activeListDepth(activeListDepth)
    ) execRes ();

    completionIf #(
        .dataWidth(dataWidth),
        .activeListDepth(activeListDepth)
    ) cmpWrite ();

    intExecUnit #(
        .dataWidth(dataWidth),
        .phyRegCount(phyRegCount),
        .activeListDepth(activeListDepth)
    ) u_execUnit (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .clear(clear),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueSrcA(issueSrcA),
        .issueSrcB(issueSrcB),
        .issueImm(issueImm),
        .issuePc(issuePc),
        .issuePredNextPc(issuePredNextPc),
        .issueDst(issueDst),
        .issueWriteReg(issueWriteReg),
        .issueAlPtr(issueAlPtr),
        .issueOperandReady(issueOperandReady),
        .res(execRes.exec)
    );

    intRegWriteStage #(
        .dataWidth(dataWidth),
        .phyRegCount(phyRegCount),
        .activeListDepth(activeListDepth)
    ) u_regWriteStage (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .clear(clear),
        .flushValid(flushValid),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .res(execRes.stage),
        .regWe(regWe),
        .regNum(regNum),
        .regData(regData),
        .cmp(cmpWrite.stage),
        .brValid(brValid),
        .brNextPc(brNextPc),
        .replayValid(replayValid),
        .replayAlPtr(replayAlPtr)
    );

    intRegFile #(
        .dataWidth(dataWidth),
        .phyRegCount(phyRegCount)
    ) u_regFile (
        .ctrl(ctrl),
        .rst(rst),
        .regWe(regWe),
        .regNum(regNum),
        .regData(regData),
        .regReadNum(regReadNum),
        .regReadData(regReadData)
    );

    completionTable #(
        .dataWidth(dataWidth),
        .activeListDepth(activeListDepth)
    ) u_completionTable (
        .ctrl(ctrl),
        .rst(rst),
        .cmp(cmpWrite.tableSide),
        .alReadPtr(alReadPtr),
        .alReadState(alReadState),
        .alReadFaultAddr(alReadFaultAddr)
    );

endmodule

`default_nettype wire

//--- rtl/completionTable.sv
////////////////////////////////////////
// Execution state and fault address per active-list entry
// Written by the register-write stage, read for observation
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module completionTable #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
) (
    input wire ctrl,
    input wire rst,
    completionIf.tableSide cmp,
    input wire [$clog2(activeListDepth)-1:0] alReadPtr,
    output wbPkg::ExecState alReadState,
    output logic [dataWidth-1:0] alReadFaultAddr
);
    import wbPkg::*;

    ExecState stateArr [activeListDepth];
    logic [dataWidth-1:0] faultArr [activeListDepth];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < activeListDepth; i++) begin
                stateArr[i] <= EXEC_STATE_NOT_FINISHED;
                faultArr[i] <= '0;
            end
        end else if (cmp.write) begin
            stateArr[cmp.ptr] <= cmp.state;
            faultArr[cmp.ptr] <= cmp.faultAddr;
        end
    end

    assign alReadState = stateArr[alReadPtr];
    assign alReadFaultAddr = faultArr[alReadPtr];

endmodule

`default_nettype wire

//--- rtl/intRegFile.sv
////////////////////////////////////////
// Physical integer register file
// One write port, one combinational read port
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module intRegFile #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int phyRegCount = wbPkg::PHY_REG_COUNT
) (
    input wire ctrl,
    input wire rst,
    input wire regWe,
    input wire [$clog2(phyRegCount)-1:0] regNum,
    input wire [dataWidth-1:0] regData,
    input wire [$clog2(phyRegCount)-1:0] regReadNum,
    output logic [dataWidth-1:0] regReadData
);
    logic [dataWidth-1:0] regs [phyRegCount];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < phyRegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[regNum] <= regData;
        end
    end

    assign regReadData = regs[regReadNum];

endmodule

`default_nettype wire

//--- rtl/intRegWriteStage.sv
////////////////////////////////////////
// Register-write stage with stall, clear and flush
// Makes the writeback, completion, branch and replay decisions
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module intRegWriteStage #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int phyRegCount = wbPkg::PHY_REG_COUNT,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
) (
    input wire ctrl,
    input wire rst,
    input wire stall,
    input wire clear,
    input wire flushValid,
    input wire [$clog2(activeListDepth)-1:0] flushHead,
    input wire [$clog2(activeListDepth)-1:0] flushTail,
    execResultIf.stage res,
    output logic regWe,
    output logic [$clog2(phyRegCount)-1:0] regNum,
    output logic [dataWidth-1:0] regData,
    completionIf.stage cmp,
    output logic brValid,
    output logic [dataWidth-1:0] brNextPc,
    output logic replayValid,
    output logic [$clog2(activeListDepth)-1:0] replayAlPtr
);
    import wbPkg::*;

    localparam int regNumBits = $clog2(phyRegCount);
    localparam int ptrBits = $clog2(activeListDepth);

    logic pipeValid;
    logic pipeDataValid;
    logic [dataWidth-1:0] pipeResult;
    logic pipeWriteReg;
    logic [regNumBits-1:0] pipeDst;
    logic [ptrBits-1:0] pipePtr;
    logic pipeIsBranch;
    logic pipeTaken;
    logic [dataWidth-1:0] pipeNextPc;
    logic pipeMissPred;

    logic inRange;
    logic flushed;
    logic update;
    logic misaligned;

    always_ff @(posedge ctrl) begin
        if (rst || clear) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= res.valid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            pipeDataValid <= res.dataValid;
            pipeResult <= res.result;
            pipeWriteReg <= res.writeReg;
            pipeDst <= res.dstReg;
            pipePtr <= res.activeListPtr;
            pipeIsBranch <= res.isBranch;
            pipeTaken <= res.brTaken;
            pipeNextPc <= res.brNextPc;
            pipeMissPred <= res.brMissPred;
        end
    end

    // Circular range [head, tail); equal pointers mean nothing to flush
    always_comb begin
        if (flushHead == flushTail) begin
            inRange = 1'b0;
        end else if (flushHead < flushTail) begin
            inRange = (pipePtr >= flushHead) && (pipePtr < flushTail);
        end else begin
            inRange = (pipePtr >= flushHead) || (pipePtr < flushTail);
        end
        flushed = flushValid && inRange;
    end

    assign update = pipeValid && !stall && !clear && !flushed;

    assign regWe = update && pipeWriteReg && pipeDataValid;
    assign regNum = pipeDst;
    assign regData = pipeResult;

    // Only a taken branch actually jumps to its target
    assign misaligned = pipeIsBranch && pipeTaken &&
                        (pipeNextPc[INSN_ADDR_BITS-1:0] != '0);

    always_comb begin
        cmp.faultAddr = '0;
        if (!pipeDataValid) begin
            cmp.state = EXEC_STATE_NOT_FINISHED;
        end else if (misaligned) begin
            cmp.state = EXEC_STATE_FAULT_INSN_MISALIGNED;
            cmp.faultAddr = pipeNextPc;
        end else if (pipeMissPred) begin
            cmp.state = EXEC_STATE_REFETCH_NEXT;
        end else begin
            cmp.state = EXEC_STATE_SUCCESS;
        end
    end

    assign cmp.write = update;
    assign cmp.ptr = pipePtr;

    // Branch report to fetch
    assign brValid = update && pipeDataValid && pipeIsBranch;
    assign brNextPc = pipeNextPc;

    // Replay request when operands were not ready
    assign replayValid = update && !pipeDataValid;
    assign replayAlPtr = pipePtr;

endmodule

`default_nettype wire

//--- rtl/intExecUnit.sv
////////////////////////////////////////
// Integer ALU and branch resolver with one result slot
// Result appears one cycle after issue; holds under stall
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module intExecUnit #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int phyRegCount = wbPkg::PHY_REG_COUNT,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
) (
    input wire ctrl,
    input wire rst,
    input wire stall,
    input wire clear,
    input wire issueValid,
    input var wbPkg::IntOpType issueOp,
    input wire [dataWidth-1:0] issueSrcA,
    input wire [dataWidth-1:0] issueSrcB,
    input wire [dataWidth-1:0] issueImm,
    input wire [dataWidth-1:0] issuePc,
    input wire [dataWidth-1:0] issuePredNextPc,
    input wire [$clog2(phyRegCount)-1:0] issueDst,
    input wire issueWriteReg,
    input wire [$clog2(activeListDepth)-1:0] issueAlPtr,
    input wire issueOperandReady,
    execResultIf.exec res
);
    import wbPkg::*;

    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] nextPc;
    logic isBr;
    logic taken;

    always_comb begin
        pcPlus4 = issuePc + dataWidth'(4);
        aluOut = '0;
        isBr = 1'b0;
        taken = 1'b0;
        case (issueOp)
            INT_OP_ADD: aluOut = issueSrcA + issueSrcB;
            INT_OP_SUB: aluOut = issueSrcA - issueSrcB;
            INT_OP_AND: aluOut = issueSrcA & issueSrcB;
            INT_OP_OR:  aluOut = issueSrcA | issueSrcB;
            INT_OP_XOR: aluOut = issueSrcA ^ issueSrcB;
            // Conditional branches leave the result at zero
            INT_OP_BEQ: begin
                isBr = 1'b1;
                taken = (issueSrcA == issueSrcB);
            end
            INT_OP_BNE: begin
                isBr = 1'b1;
                taken = (issueSrcA != issueSrcB);
            end
            INT_OP_JAL: begin
                isBr = 1'b1;
                taken = 1'b1;
                aluOut = pcPlus4;
            end
            default: aluOut = '0;
        endcase
        nextPc = taken ? (issuePc + issueImm) : pcPlus4;
    end

    // Slot occupancy
    always_ff @(posedge ctrl) begin
        if (rst || clear) begin
            res.valid <= 1'b0;
        end else if (!stall) begin
            res.valid <= issueValid;
        end
    end

    // Result payload
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            res.dataValid <= issueOperandReady;
            res.result <= aluOut;
            res.writeReg <= issueWriteReg;
            res.dstReg <= issueDst;
            res.activeListPtr <= issueAlPtr;
            res.isBranch <= isBr;
            res.brTaken <= taken;
            res.brNextPc <= nextPc;
            res.brMissPred <= isBr && (nextPc != issuePredNextPc);
        end
    end

endmodule

`default_nettype wire

//--- rtl/completionIf.sv
////////////////////////////////////////
// Completion-table write from the register-write stage
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface completionIf #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
);
    import wbPkg::*;

    localparam int ptrBits = $clog2(activeListDepth);

    logic write;
    logic [ptrBits-1:0] ptr;
    ExecState state;
    logic [dataWidth-1:0] faultAddr;

    modport stage(output write, ptr, state, faultAddr);

    // Completion table receives the write
    modport tableSide(input write, ptr, state, faultAddr);

endinterface

`default_nettype wire

//--- rtl/execResultIf.sv
////////////////////////////////////////
// One execution result, from the integer execution unit
// to the register-write stage
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface execResultIf #(
    parameter int dataWidth = wbPkg::DATA_WIDTH,
    parameter int phyRegCount = wbPkg::PHY_REG_COUNT,
    parameter int activeListDepth = wbPkg::ACTIVE_LIST_DEPTH
);
    localparam int regNumBits = $clog2(phyRegCount);
    localparam int ptrBits = $clog2(activeListDepth);

    logic valid;
    // Low when operands were not ready at issue
    logic dataValid;
    logic [dataWidth-1:0] result;
    logic writeReg;
    logic [regNumBits-1:0] dstReg;
    logic [ptrBits-1:0] activeListPtr;

    // Branch resolution
    logic isBranch;
    logic brTaken;
    logic [dataWidth-1:0] brNextPc;
    logic brMissPred;

    modport exec(
        output valid, dataValid, result, writeReg, dstReg, activeListPtr,
        output isBranch, brTaken, brNextPc, brMissPred
    );

    modport stage(
        input valid, dataValid, result, writeReg, dstReg, activeListPtr,
        input isBranch, brTaken, brNextPc, brMissPred
    );

endinterface

`default_nettype wire

//--- rtl/wbPkg.sv
////////////////////////////////////////
// Shared types and sizing for the integer writeback path
// Import into module bodies; use scoped names in headers
////////////////////////////////////////

`default_nettype none

package wbPkg;

    // Default sizes that the top level passes down as parameters
    localparam int DATA_WIDTH = 32;
    localparam int PHY_REG_COUNT = 32;
    localparam int ACTIVE_LIST_DEPTH = 16;

    // Low target bits that must be zero for a legal branch target
    localparam int INSN_ADDR_BITS = 2;

    // Integer micro-op kinds
    typedef enum logic [2:0] {
        INT_OP_ADD,
        INT_OP_SUB,
        INT_OP_AND,
        INT_OP_OR,
        INT_OP_XOR,
        INT_OP_BEQ,
        INT_OP_BNE,
        INT_OP_JAL
    } IntOpType;

    // Completion state recorded per active-list entry
    typedef enum logic [1:0] {
        EXEC_STATE_NOT_FINISHED,
        EXEC_STATE_SUCCESS,
        EXEC_STATE_REFETCH_NEXT,
        EXEC_STATE_FAULT_INSN_MISALIGNED
    } ExecState;

endpackage

`default_nettype wire
